// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= exec_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell cat sources.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) sources.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f sources.f

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Simulation finished: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/exec_checks.sv ====
`timescale 1ns/1ps

module exec_checks
    import exec_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              in_ready,
    input  logic              exp_ready,
    input  logic              out_valid,
    input  logic              exp_out_valid,
    input  logic [reg_aw-1:0] out_rd,
    input  logic [reg_aw-1:0] exp_rd,
    input  logic              out_we,
    input  logic              exp_we,
    input  logic              out_is_load,
    input  logic              exp_is_load,
    input  logic [xlen-1:0]   out_result,
    input  logic [xlen-1:0]   exp_result,
    input  logic [xlen-1:0]   out_store_data,
    input  logic [xlen-1:0]   exp_store,
    input  logic              redirect_valid,
    input  logic              exp_rv,
    input  logic [xlen-1:0]   redirect_pc,
    input  logic [xlen-1:0]   exp_rpc,
    output int                errors
);

    initial errors = 0;

    task automatic report_mismatch(input string name, input logic [xlen-1:0] exp,
                                   input logic [xlen-1:0] act);
        errors++;
        $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp, act);
    endtask

    c_ready: assert property (@(posedge clk) disable iff (rst) in_ready == exp_ready)
        else report_mismatch("in_ready", 32'($sampled(exp_ready)), 32'($sampled(in_ready)));
    c_valid: assert property (@(posedge clk) disable iff (rst) out_valid == exp_out_valid)
        else report_mismatch("out_valid", 32'($sampled(exp_out_valid)),
                             32'($sampled(out_valid)));
    c_rd: assert property (@(posedge clk) disable iff (rst) out_valid |-> out_rd == exp_rd)
        else report_mismatch("out_rd", 32'($sampled(exp_rd)), 32'($sampled(out_rd)));
    c_we: assert property (@(posedge clk) disable iff (rst) out_valid |-> out_we == exp_we)
        else report_mismatch("out_we", 32'($sampled(exp_we)), 32'($sampled(out_we)));
    c_ld: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> out_is_load == exp_is_load)
        else report_mismatch("out_is_load", 32'($sampled(exp_is_load)),
                             32'($sampled(out_is_load)));
    c_result: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> out_result == exp_result)
        else report_mismatch("out_result", $sampled(exp_result), $sampled(out_result));
    c_store: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> out_store_data == exp_store)
        else report_mismatch("out_store_data", $sampled(exp_store), $sampled(out_store_data));
    c_redirect: assert property (@(posedge clk) disable iff (rst) redirect_valid == exp_rv)
        else report_mismatch("redirect_valid", 32'($sampled(exp_rv)),
                             32'($sampled(redirect_valid)));
    c_target: assert property (@(posedge clk) disable iff (rst)
        redirect_valid |-> redirect_pc == exp_rpc)
        else report_mismatch("redirect_pc", $sampled(exp_rpc), $sampled(redirect_pc));

endmodule

// ==== bench/exec_tb.sv ====
`timescale 1ns/1ps

module exec_tb
    import exec_pkg::*;
();

    logic clk, rst, in_valid, in_ready, src1_is_pc, src2_is_imm, is_load, gpr_we;
    logic lsu_ready, load_valid, pc_update, out_valid, out_we, out_is_load, redirect_valid;
    logic [xlen-1:0] pc, rs1_val, rs2_val, imm, load_data, out_result, out_store_data;
    logic [xlen-1:0] redirect_pc;
    logic [reg_aw-1:0] rd, rs1, rs2, out_rd;
    logic [alu_op_w-1:0] alu_op;
    logic [cond_w-1:0] br_kind;

    // shadow model state, slot 0 is the youngest write.
    logic [reg_aw-1:0] m_rd [bypass_depth];
    logic [xlen-1:0] m_data [bypass_depth];
    logic m_pend [bypass_depth];
    logic m_rv, e_out_valid, e_we, e_is_load, e_wait1, e_wait2, e_ready, e_taken, e_live;
    logic [xlen-1:0] m_rpc, e_result, e_store, e_src1, e_src2, e_a, e_b, e_alu, e_tgt, e_res;
    logic [reg_aw-1:0] e_rd;
    int seed = 29584;
    int timeouts = 0;
    int mark;

    exec_top i_dut (.*);

    exec_checks u_checks (
        .clk(clk), .rst(rst), .in_ready(in_ready), .exp_ready(e_ready),
        .out_valid(out_valid), .exp_out_valid(e_out_valid), .out_rd(out_rd), .exp_rd(e_rd),
        .out_we(out_we), .exp_we(e_we), .out_is_load(out_is_load), .exp_is_load(e_is_load),
        .out_result(out_result), .exp_result(e_result), .out_store_data(out_store_data),
        .exp_store(e_store), .redirect_valid(redirect_valid), .exp_rv(m_rv),
        .redirect_pc(redirect_pc), .exp_rpc(m_rpc), .errors()
    );

    function automatic logic [xlen-1:0] fwd_operand(input logic [reg_aw-1:0] rs,
                                                    input logic [xlen-1:0] rf, output logic pend);
        logic found;
        logic [xlen-1:0] val;
        found = 1'b0;
        val = rf;
        pend = 1'b0;
        for (int k = 0; k < bypass_depth; k++) begin
            if (!found && rs != '0 && m_rd[k] == rs) begin
                found = 1'b1;
                val = m_data[k];
                pend = m_pend[k];
            end
        end
        return val;
    endfunction

    function automatic logic [xlen-1:0] ref_alu(input logic [alu_op_w-1:0] op,
                                                input logic [xlen-1:0] a, input logic [xlen-1:0] b);
        logic signed [xlen-1:0] sa;
        logic signed [xlen-1:0] sb;
        sa = a;
        sb = b;
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_sll:  return a << b[4:0];
            op_srl:  return a >> b[4:0];
            op_sra:  return sa >>> b[4:0];
            op_slt:  return (sa < sb) ? 32'd1 : 32'd0;
            op_sltu: return (a < b) ? 32'd1 : 32'd0;
            op_lui_pass: return b;
            default: return '0;
        endcase
    endfunction

    function automatic logic ref_taken(input logic [cond_w-1:0] kind,
                                       input logic [xlen-1:0] a, input logic [xlen-1:0] b);
        case (kind)
            br_always: return 1'b1;
            br_eq:     return a == b;
            br_ne:     return a != b;
            br_lt:     return $signed(a) < $signed(b);
            br_ge:     return $signed(a) >= $signed(b);
            br_ltu:    return a < b;
            br_geu:    return a >= b;
            default:   return 1'b0;
        endcase
    endfunction

    always_comb begin
        e_src1  = fwd_operand(rs1, rs1_val, e_wait1);
        e_src2  = fwd_operand(rs2, rs2_val, e_wait2);
        e_ready = lsu_ready && !e_wait1 && !e_wait2;
        e_a     = src1_is_pc ? pc : e_src1;
        e_b     = src2_is_imm ? imm : e_src2;
        e_alu   = ref_alu(alu_op, e_a, e_b);
        e_taken = ref_taken(br_kind, e_src1, e_src2);
        e_tgt   = src1_is_pc ? pc + imm : e_alu; // jalr adds rs1 and imm.
        e_res   = (br_kind != br_none) ? pc + 32'd4 : e_alu;
        e_live  = in_valid && e_ready && !m_rv;
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int k = 0; k < bypass_depth; k++) begin
                m_rd[k] <= '0;
                m_pend[k] <= 1'b0;
                m_data[k] <= '0;
            end
            e_out_valid <= 1'b0;
            m_rv <= 1'b0;
            m_rpc <= '0;
        end else begin
            e_out_valid <= e_live;
            if (e_live) begin
                e_rd <= rd;
                e_we <= gpr_we;
                e_is_load <= is_load;
                e_result <= e_res;
                e_store <= e_src2;
            end
            if (m_rv) begin
                if (pc_update) m_rv <= 1'b0;
            end else if (e_live && e_taken && e_tgt != pc + 32'd4) begin
                m_rv <= 1'b1;
                m_rpc <= e_tgt;
            end
            if (e_live && gpr_we) begin
                for (int k = bypass_depth - 1; k > 0; k--) begin
                    m_rd[k] <= m_rd[k-1];
                    m_pend[k] <= m_pend[k-1] && !load_valid;
                    m_data[k] <= (m_pend[k-1] && load_valid) ? load_data : m_data[k-1];
                end
                m_rd[0] <= rd;
                m_pend[0] <= is_load && rd != '0 && !load_valid;
                if (is_load) m_data[0] <= (load_valid && rd != '0) ? load_data : '0;
                else m_data[0] <= e_res;
            end else if (load_valid) begin
                for (int k = 0; k < bypass_depth; k++) begin
                    if (m_pend[k]) begin
                        m_data[k] <= load_data;
                        m_pend[k] <= 1'b0;
                    end
                end
            end
        end
    end

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic drive_instr(input logic [alu_op_w-1:0] op, input logic [cond_w-1:0] kind,
                               input logic [reg_aw-1:0] d, input logic [reg_aw-1:0] s1,
                               input logic [reg_aw-1:0] s2, input logic s1pc, input logic s2imm,
                               input logic ld, input logic we);
        logic [31:0] r;
        r = $random(seed);
        pc = {r[31:2], 2'b00};
        rs1_val = $random(seed);
        rs2_val = $random(seed);
        imm = $random(seed);
        {alu_op, br_kind, rd, rs1, rs2} = {op, kind, d, s1, s2};
        {src1_is_pc, src2_is_imm, is_load, gpr_we} = {s1pc, s2imm, ld, we};
        in_valid = 1'b1;
    endtask

    // noisy mode adds random back-pressure, load returns and fetch confirms.
    task automatic wait_accept(input bit noisy);
        logic [31:0] r;
        bit done;
        done = 1'b0;
        for (int tries = 0; tries < 200 && !done; tries++) begin
            if (noisy) begin
                r = $random(seed);
                lsu_ready = r[0] | r[1];
                load_valid = (r[3:2] == 2'b00);
                load_data = $random(seed);
                pc_update = redirect_valid && r[4];
            end
            #1;
            done = in_ready;
            @(negedge clk);
            load_valid = 1'b0;
            pc_update = 1'b0;
        end
        in_valid = 1'b0;
        if (!done) begin
            timeouts++;
            $display("timeout: instruction at pc %h was never accepted", pc);
        end
    endtask

    task automatic report_test(input string name);
        $display("test %s finished with %0d errors", name, u_checks.errors + timeouts - mark);
        mark = u_checks.errors + timeouts;
    endtask

    initial begin
        logic [31:0] r;
        {in_valid, src1_is_pc, src2_is_imm, is_load, gpr_we, load_valid, pc_update} = '0;
        {pc, rs1_val, rs2_val, imm, load_data, rd, rs1, rs2, alu_op, br_kind} = '0;
        lsu_ready = 1'b1;
        mark = 0;
        rst = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int o = 0; o <= 10; o++) begin
            for (int v = 0; v < 4; v++) begin
                drive_instr(4'(o), br_none, 4'd1, 4'd2, 4'd3, v[0], v[1], 1'b0, 1'b0);
                wait_accept(1'b0);
            end
        end
        report_test("alu opcodes");

        drive_instr(op_add, br_none, 4'd3, 4'd1, 4'd2, 1'b0, 1'b1, 1'b0, 1'b1);
        wait_accept(1'b0);
        drive_instr(op_xor, br_none, 4'd3, 4'd1, 4'd2, 1'b0, 1'b0, 1'b0, 1'b1);
        wait_accept(1'b0);
        drive_instr(op_sub, br_none, 4'd0, 4'd3, 4'd3, 1'b0, 1'b0, 1'b0, 1'b1);
        wait_accept(1'b0);
        drive_instr(op_add, br_none, 4'd4, 4'd3, 4'd0, 1'b0, 1'b0, 1'b0, 1'b1);
        wait_accept(1'b0);
        for (int i = 0; i < 4; i++) begin
            drive_instr(op_or, br_none, 4'd7, 4'd4, 4'd1, 1'b0, 1'b0, 1'b0, 1'b1);
            wait_accept(1'b0);
        end
        drive_instr(op_and, br_none, 4'd1, 4'd3, 4'd4, 1'b0, 1'b0, 1'b0, 1'b0);
        wait_accept(1'b0);
        report_test("forwarding");

        drive_instr(op_add, br_none, 4'd5, 4'd1, 4'd2, 1'b0, 1'b1, 1'b1, 1'b1);
        wait_accept(1'b0);
        drive_instr(op_add, br_none, 4'd6, 4'd5, 4'd2, 1'b0, 1'b0, 1'b0, 1'b1);
        repeat (3) @(negedge clk);
        load_valid = 1'b1;
        load_data = $random(seed);
        @(negedge clk);
        load_valid = 1'b0;
        wait_accept(1'b0);
        report_test("load stall");

        drive_instr(op_add, br_eq, 4'd0, 4'd1, 4'd1, 1'b1, 1'b1, 1'b0, 1'b0);
        rs2_val = rs1_val; // equal operands take the branch.
        wait_accept(1'b0);
        for (int i = 0; i < 2; i++) begin
            drive_instr(op_add, br_none, 4'd6, 4'd1, 4'd2, 1'b0, 1'b0, 1'b0, 1'b1);
            wait_accept(1'b0);
        end
        pc_update = 1'b1;
        @(negedge clk);
        pc_update = 1'b0;
        for (int i = 0; i < 10 && redirect_valid; i++) @(negedge clk);
        if (redirect_valid) begin
            timeouts++;
            $display("timeout: redirect stayed high after the fetch confirm");
        end
        drive_instr(op_add, br_always, 4'd2, 4'd1, 4'd1, 1'b0, 1'b1, 1'b0, 1'b1);
        imm = 32'd4;
        rs1_val = pc; // jalr to the next pc needs no redirect.
        wait_accept(1'b0);
        // x6 must still hold the write from before the squash.
        drive_instr(op_add, br_ne, 4'd0, 4'd6, 4'd6, 1'b1, 1'b1, 1'b0, 1'b0);
        wait_accept(1'b0);
        report_test("redirect");

        lsu_ready = 1'b0;
        drive_instr(op_add, br_none, 4'd2, 4'd1, 4'd3, 1'b0, 1'b0, 1'b0, 1'b1);
        repeat (5) @(negedge clk);
        lsu_ready = 1'b1;
        wait_accept(1'b0);
        for (int n = 0; n < 300; n++) begin
            r = $random(seed);
            drive_instr((r[3:0] > 4'd10) ? op_add : r[3:0], (r[5:4] == 2'b00) ? r[8:6] : br_none,
                        {1'b0, r[11:9]}, {1'b0, r[14:12]}, {1'b0, r[17:15]},
                        r[18], r[19], r[22:20] == 3'b000, r[23] | r[24]);
            wait_accept(1'b1);
        end
        report_test("back-pressure and random stream");

        $display("summary: 5 tests, %0d assertion failures, %0d timeouts",
                 u_checks.errors, timeouts);
        if (u_checks.errors == 0 && timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu
    import exec_pkg::*;
(
    input  logic [alu_op_w-1:0] op,
    input  logic [xlen-1:0]     a,
    input  logic [xlen-1:0]     b,
    input  logic [xlen-1:0]     cmp_a,
    input  logic [xlen-1:0]     cmp_b,
    input  logic [cond_w-1:0]   kind,
    output logic [xlen-1:0]     result,
    output logic                taken
);

    logic [4:0] shamt;
    logic       cmp_eq;
    logic       cmp_lt;
    logic       cmp_ltu;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            op_add:      result = a + b;
            op_sub:      result = a - b;
            op_and:      result = a & b;
            op_or:       result = a | b;
            op_xor:      result = a ^ b;
            op_sll:      result = a << shamt;
            op_srl:      result = a >> shamt;
            op_sra:      result = $unsigned($signed(a) >>> shamt);
            op_slt:      result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            op_sltu:     result = {{(xlen-1){1'b0}}, a < b};
            op_lui_pass: result = b;
            default:     result = '0;
        endcase
    end

    // branch compare looks at the raw register operands, never at pc or imm.
    assign cmp_eq  = (cmp_a == cmp_b);
    assign cmp_lt  = ($signed(cmp_a) < $signed(cmp_b));
    assign cmp_ltu = (cmp_a < cmp_b);

    always_comb begin
        case (kind)
            br_always: taken = 1'b1;
            br_eq:     taken = cmp_eq;
            br_ne:     taken = !cmp_eq;
            br_lt:     taken = cmp_lt;
            br_ge:     taken = !cmp_lt;
            br_ltu:    taken = cmp_ltu;
            br_geu:    taken = !cmp_ltu;
            default:   taken = 1'b0; // br_none.
        endcase
    end

endmodule

// ==== design/bypass_slot.sv ====
`timescale 1ns/1ps

module bypass_slot
    import exec_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              shift,
    input  logic [reg_aw-1:0] in_rd,
    input  logic [xlen-1:0]   in_data,
    input  logic              in_is_load,
    input  logic              load_valid,
    input  logic [xlen-1:0]   load_data,
    output logic [reg_aw-1:0] slot_rd,
    output logic [xlen-1:0]   slot_data,
    output logic              slot_pending
);

    logic fill_in;
    logic fill_here;

    assign fill_in   = load_valid && in_is_load;   // entry arrives pending.
    assign fill_here = load_valid && slot_pending;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot_rd      <= '0;
            slot_pending <= 1'b0;
        end else if (shift) begin
            slot_rd      <= in_rd;
            slot_pending <= in_is_load && !load_valid;
        end else if (fill_here) begin
            slot_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (shift) begin
            slot_data <= fill_in ? load_data : in_data;
        end else if (fill_here) begin
            slot_data <= load_data;
        end
    end

    // the core never marks an x0 write as an outstanding load.
    a_no_pending_x0: assert property (
        @(posedge clk) disable iff (rst)
        slot_pending |-> (slot_rd != '0)
    );

endmodule

// ==== design/exec_pkg.sv ====
package exec_pkg;

    localparam int xlen         = 32;
    localparam int reg_aw       = 4;  // sixteen architectural registers.
    localparam int bypass_depth = 4;
    localparam int alu_op_w     = 4;
    localparam int cond_w       = 3;

    localparam logic [alu_op_w-1:0] op_add      = 4'd0;
    localparam logic [alu_op_w-1:0] op_sub      = 4'd1;
    localparam logic [alu_op_w-1:0] op_and      = 4'd2;
    localparam logic [alu_op_w-1:0] op_or       = 4'd3;
    localparam logic [alu_op_w-1:0] op_xor      = 4'd4;
    localparam logic [alu_op_w-1:0] op_sll      = 4'd5;
    localparam logic [alu_op_w-1:0] op_srl      = 4'd6;
    localparam logic [alu_op_w-1:0] op_sra      = 4'd7;
    localparam logic [alu_op_w-1:0] op_slt      = 4'd8;
    localparam logic [alu_op_w-1:0] op_sltu     = 4'd9;
    localparam logic [alu_op_w-1:0] op_lui_pass = 4'd10; // result is b.

    localparam logic [cond_w-1:0] br_none   = 3'd0;
    localparam logic [cond_w-1:0] br_always = 3'd1; // jal and jalr.
    localparam logic [cond_w-1:0] br_eq     = 3'd2;
    localparam logic [cond_w-1:0] br_ne     = 3'd3;
    localparam logic [cond_w-1:0] br_lt     = 3'd4;
    localparam logic [cond_w-1:0] br_ge     = 3'd5;
    localparam logic [cond_w-1:0] br_ltu    = 3'd6;
    localparam logic [cond_w-1:0] br_geu    = 3'd7;

endpackage

// ==== design/exec_top.sv ====
`timescale 1ns/1ps

module exec_top
    import exec_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    output logic                in_ready,
    input  logic [xlen-1:0]     pc,
    input  logic [reg_aw-1:0]   rd,
    input  logic [reg_aw-1:0]   rs1,
    input  logic [reg_aw-1:0]   rs2,
    input  logic [xlen-1:0]     rs1_val,
    input  logic [xlen-1:0]     rs2_val,
    input  logic [xlen-1:0]     imm,
    input  logic [alu_op_w-1:0] alu_op,
    input  logic [cond_w-1:0]   br_kind,
    input  logic                src1_is_pc,
    input  logic                src2_is_imm,
    input  logic                is_load,
    input  logic                gpr_we,
    input  logic                lsu_ready,
    input  logic                load_valid,
    input  logic [xlen-1:0]     load_data,
    input  logic                pc_update,
    output logic                out_valid,
    output logic [reg_aw-1:0]   out_rd,
    output logic                out_we,
    output logic                out_is_load,
    output logic [xlen-1:0]     out_result,
    output logic [xlen-1:0]     out_store_data,
    output logic                redirect_valid,
    output logic [xlen-1:0]     redirect_pc
);

    logic [xlen-1:0]   src1;
    logic [xlen-1:0]   src2;
    logic              operand_wait;
    logic              push;
    logic [reg_aw-1:0] push_rd;
    logic [xlen-1:0]   push_data;
    logic              push_is_load;
    logic [reg_aw-1:0] slot_rd      [bypass_depth];
    logic [xlen-1:0]   slot_data    [bypass_depth];
    logic              slot_pending [bypass_depth];

    exu_core u_core (.*);

    operand_forward u_fwd (.*);

    // slot 0 takes the new write, each later slot takes its neighbour.
    for (genvar g = 0; g < bypass_depth; g++) begin : g_slot
        if (g == 0) begin : g_head
            bypass_slot u_slot (
                .clk          (clk),
                .rst          (rst),
                .shift        (push),
                .in_rd        (push_rd),
                .in_data      (push_data),
                .in_is_load   (push_is_load),
                .load_valid   (load_valid),
                .load_data    (load_data),
                .slot_rd      (slot_rd[g]),
                .slot_data    (slot_data[g]),
                .slot_pending (slot_pending[g])
            );
        end else begin : g_tail
            bypass_slot u_slot (
                .clk          (clk),
                .rst          (rst),
                .shift        (push),
                .in_rd        (slot_rd[g-1]),
                .in_data      (slot_data[g-1]),
                .in_is_load   (slot_pending[g-1]),
                .load_valid   (load_valid),
                .load_data    (load_data),
                .slot_rd      (slot_rd[g]),
                .slot_data    (slot_data[g]),
                .slot_pending (slot_pending[g])
            );
        end
    end

endmodule

// ==== design/exu_core.sv ====
`timescale 1ns/1ps

module exu_core
    import exec_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  logic [xlen-1:0]     pc,
    input  logic [reg_aw-1:0]   rd,
    input  logic [xlen-1:0]     imm,
    input  logic [alu_op_w-1:0] alu_op,
    input  logic [cond_w-1:0]   br_kind,
    input  logic                src1_is_pc,
    input  logic                src2_is_imm,
    input  logic                is_load,
    input  logic                gpr_we,
    input  logic [xlen-1:0]     src1,
    input  logic [xlen-1:0]     src2,
    input  logic                operand_wait,
    input  logic                lsu_ready,
    input  logic                pc_update,
    output logic                in_ready,
    output logic                out_valid,
    output logic [reg_aw-1:0]   out_rd,
    output logic                out_we,
    output logic                out_is_load,
    output logic [xlen-1:0]     out_result,
    output logic [xlen-1:0]     out_store_data,
    output logic                redirect_valid,
    output logic [xlen-1:0]     redirect_pc,
    output logic                push,
    output logic [reg_aw-1:0]   push_rd,
    output logic [xlen-1:0]     push_data,
    output logic                push_is_load
);

    logic            accept;
    logic            live;
    logic            is_xfer;
    logic            taken;
    logic            redirect_hit;
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] seq_pc;
    logic [xlen-1:0] target;
    logic [xlen-1:0] result;

    assign in_ready = lsu_ready && !operand_wait;
    assign accept   = in_valid && in_ready;
    assign live     = accept && !redirect_valid; // wrong-path work is dropped.

    assign alu_a = src1_is_pc ? pc : src1;
    assign alu_b = src2_is_imm ? imm : src2;

    alu u_alu (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .cmp_a  (src1),
        .cmp_b  (src2),
        .kind   (br_kind),
        .result (alu_result),
        .taken  (taken)
    );

    assign is_xfer = (br_kind != br_none);
    assign seq_pc  = pc + 32'd4;
    assign target  = src1_is_pc ? pc + imm : alu_result; // alu sum for jalr.
    assign result  = is_xfer ? seq_pc : alu_result;      // link value.

    assign redirect_hit = live && taken && (target != seq_pc);

    assign push         = live && gpr_we;
    assign push_rd      = rd;
    assign push_data    = is_load ? '0 : result;
    assign push_is_load = is_load && (rd != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid      <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            out_valid <= live;
            if (redirect_valid) begin
                if (pc_update) begin
                    redirect_valid <= 1'b0;
                end
            end else if (redirect_hit) begin
                redirect_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (live) begin
            out_rd         <= rd;
            out_we         <= gpr_we;
            out_is_load    <= is_load;
            out_result     <= result;
            out_store_data <= src2;
        end
        if (redirect_hit) begin
            redirect_pc <= target; // held until fetch confirms.
        end
    end

    a_squash_no_out: assert property (
        @(posedge clk) disable iff (rst)
        (in_valid && in_ready && redirect_valid) |=> !out_valid
    );

    a_backpressure: assert property (
        @(posedge clk) disable iff (rst)
        !lsu_ready |-> !in_ready
    );

endmodule

// ==== design/operand_forward.sv ====
`timescale 1ns/1ps

module operand_forward
    import exec_pkg::*;
(
    input  logic [reg_aw-1:0] rs1,
    input  logic [reg_aw-1:0] rs2,
    input  logic [xlen-1:0]   rs1_val,
    input  logic [xlen-1:0]   rs2_val,
    input  logic [reg_aw-1:0] slot_rd      [bypass_depth],
    input  logic [xlen-1:0]   slot_data    [bypass_depth],
    input  logic              slot_pending [bypass_depth],
    output logic [xlen-1:0]   src1,
    output logic [xlen-1:0]   src2,
    output logic              operand_wait
);

    logic wait1;
    logic wait2;

    // slot 0 holds the youngest write, so it is visited last and wins.
    function automatic logic [xlen-1:0] pick(
        input  logic [reg_aw-1:0] rs,
        input  logic [xlen-1:0]   rf_val,
        output logic              pend
    );
        logic [xlen-1:0] data;
        data = rf_val;
        pend = 1'b0;
        for (int k = bypass_depth - 1; k >= 0; k--) begin
            if ((rs != '0) && (slot_rd[k] == rs)) begin
                data = slot_data[k];
                pend = slot_pending[k]; // an older pending match is shadowed.
            end
        end
        return data;
    endfunction

    always_comb begin
        src1 = pick(rs1, rs1_val, wait1);
        src2 = pick(rs2, rs2_val, wait2);
    end

    assign operand_wait = wait1 || wait2;

endmodule

// ==== sources.f ====
design/exec_pkg.sv
design/alu.sv
design/bypass_slot.sv
design/operand_forward.sv
design/exu_core.sv
design/exec_top.sv
bench/exec_checks.sv
bench/exec_tb.sv
